// File: bench/readout_tb.sv
`timescale 1ns/10ps

module readout_tb;

  // build identification, also known to the model
  localparam logic [31:0] SYN_DATE = 32'h1A2B_3C4D;
  localparam logic [7:0]  FPGA_VER = 8'h5C;
  // wait limits in clock cycles
  localparam int ACK_TIMEOUT  = 8;
  localparam int WORD_TIMEOUT = 200;
  // quiet window after a run or a gated start
  localparam int IDLE_CYCLES  = 32;

  logic               clk156 = 1'b0;
  logic               rst_n_i;
  logic               rbcp_act_i;
  logic [31:0]        rbcp_addr_i;
  logic               rbcp_we_i;
  readout_pkg::byte_t rbcp_wd_i;
  logic               rbcp_re_i;
  readout_pkg::byte_t rbcp_rd_o;
  logic               rbcp_ack_o;
  logic               tcp_open_i;
  logic               tx_afull_i;
  logic [63:0]        tx_d_o;
  logic [3:0]         tx_b_o;
  logic               tim_1s_i;
  logic               bled_o;
  logic               gled_o;

  // reference model state, fed by register writes
  logic               sel_model;
  logic [31:0]        seq_model;
  logic [63:0]        num_model;
  logic               bled_model;

  always #50 clk156 = ~clk156;

  readout_top #(
    .SYN_DATE    (SYN_DATE),
    .FPGA_VER    (FPGA_VER)
  ) readout_top_inst (
    .clk156      (clk156),
    .rst_n_i     (rst_n_i),
    .rbcp_act_i  (rbcp_act_i),
    .rbcp_addr_i (rbcp_addr_i),
    .rbcp_we_i   (rbcp_we_i),
    .rbcp_wd_i   (rbcp_wd_i),
    .rbcp_re_i   (rbcp_re_i),
    .rbcp_rd_o   (rbcp_rd_o),
    .rbcp_ack_o  (rbcp_ack_o),
    .tcp_open_i  (tcp_open_i),
    .tx_afull_i  (tx_afull_i),
    .tx_d_o      (tx_d_o),
    .tx_b_o      (tx_b_o),
    .tim_1s_i    (tim_1s_i),
    .bled_o      (bled_o),
    .gled_o      (gled_o)
  );

  ////////////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus and pin tasks, all called on a falling edge
  ////////////////////////////////////////////////////////////

  // one RBCP strobe, then wait for the ack
  task automatic rbcp_access(input logic wr, input logic [31:0] addr,
                             input readout_pkg::byte_t wd,
                             output readout_pkg::byte_t rd);
    int waited;
    waited = 0;
    rbcp_act_i  = 1'b1;
    rbcp_addr_i = addr;
    rbcp_we_i   = wr;
    rbcp_re_i   = ~wr;
    rbcp_wd_i   = wd;
    @(negedge clk156);
    rbcp_act_i = 1'b0;
    rbcp_we_i  = 1'b0;
    rbcp_re_i  = 1'b0;
    while (!rbcp_ack_o) begin
      if (waited >= ACK_TIMEOUT) begin
        $display("ERROR: no RBCP acknowledge for address 0x%0h", addr);
        abort_run();
      end
      @(negedge clk156);
      waited++;
    end
    rd = rbcp_rd_o;
  endtask

  // shadow of the settings, big endian byte lanes
  task automatic model_write(input logic [31:0] addr, input readout_pkg::byte_t data);
    int lane;
    lane = 0;
    if (addr == readout_pkg::ADDR_CTRL) begin
      sel_model = data[1];
    end else if ((addr & ~32'h3) == readout_pkg::ADDR_SEQ) begin
      lane = 3 - int'(addr[1:0]);
      seq_model[8*lane +: 8] = data;
    end else if ((addr & ~32'h7) == readout_pkg::ADDR_NUM) begin
      lane = 7 - int'(addr[2:0]);
      num_model[8*lane +: 8] = data;
    end
  endtask

  task automatic set_session(input logic open);
    tcp_open_i = open;
    @(negedge clk156);
    // green lamp is active low
    check_value("gled_o", 64'(gled_o), 64'(!open));
  endtask

  task automatic one_second_tick();
    check_value("bled_o", 64'(bled_o), 64'(bled_model));
    tim_1s_i = 1'b1;
    @(negedge clk156);
    tim_1s_i   = 1'b0;
    bled_model = ~bled_model;
    check_value("bled_o", 64'(bled_o), 64'(bled_model));
  endtask

  task automatic expect_no_words(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk156);
      check_value("tx_b_o", 64'(tx_b_o), 64'd0);
    end
  endtask

  // take words under random almost-full
  // partial run closes the session right after the last one
  task automatic collect_words(input int words, input logic err, input logic partial);
    int          got;
    int          waited;
    logic [63:0] total;
    logic [63:0] exp_d;
    logic [3:0]  exp_b;
    got    = 0;
    waited = 0;
    total  = 64'd0;
    while (got < words) begin
      @(negedge clk156);
      if (tx_b_o != 4'd0) begin
        exp_d = sel_model ? {seq_model, seq_model} : 64'(got);
        // corrupted first byte on the first word only
        if (err && got == 0) begin
          exp_d[63:56] = ~exp_d[63:56];
        end
        exp_b = 4'd8;
        if (!partial && got == words - 1 && num_model[2:0] != 3'd0) begin
          exp_b = {1'b0, num_model[2:0]};
        end
        check_value("tx_d_o", tx_d_o, exp_d);
        check_value("tx_b_o", 64'(tx_b_o), 64'(exp_b));
        total  = total + 64'(tx_b_o);
        got++;
        waited = 0;
      end else begin
        waited++;
        if (waited > WORD_TIMEOUT) begin
          $display("ERROR: timed out waiting for word %0d of %0d", got, words);
          abort_run();
        end
      end
      tx_afull_i = (($urandom % 4) == 0);
    end
    tx_afull_i = 1'b0;
    if (partial) begin
      tcp_open_i = 1'b0;
    end else begin
      check_value("byte total", total, num_model);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // command sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int                 fd;
    string              line;
    logic [7:0]         cmd;
    logic [31:0]        a;
    logic [31:0]        b;
    readout_pkg::byte_t rd;
    void'($urandom(51));
    rst_n_i     = 1'b0;
    rbcp_act_i  = 1'b0;
    rbcp_addr_i = 32'd0;
    rbcp_we_i   = 1'b0;
    rbcp_wd_i   = 8'h00;
    rbcp_re_i   = 1'b0;
    tcp_open_i  = 1'b0;
    tx_afull_i  = 1'b0;
    tim_1s_i    = 1'b0;
    sel_model   = 1'b0;
    seq_model   = readout_pkg::SEQ_PATTERN_DEFAULT;
    num_model   = 64'd0;
    bled_model  = 1'b0;
    repeat (10) @(negedge clk156);
    rst_n_i = 1'b1;
    @(negedge clk156);
    // state right after reset
    check_value("rbcp_ack_o", 64'(rbcp_ack_o), 64'd0);
    check_value("tx_b_o", 64'(tx_b_o), 64'd0);
    check_value("bled_o", 64'(bled_o), 64'd0);
    fd = $fopen("bench/tb_input.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open bench/tb_input.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      line = "";
      cmd  = 8'h20;
      a    = 32'd0;
      b    = 32'd0;
      void'($fgets(line, fd));
      void'($sscanf(line, "%c %h %h", cmd, a, b));
      case (cmd)
        "W": begin
          rbcp_access(1'b1, a, b[7:0], rd);
          model_write(a, b[7:0]);
        end
        "R": begin
          rbcp_access(1'b0, a, 8'h00, rd);
          check_value("rbcp_rd_o", 64'(rd), 64'(b[7:0]));
        end
        "S": set_session(a[0]);
        "T": one_second_tick();
        "G": begin
          if (a == 32'd0) begin
            expect_no_words(IDLE_CYCLES);
          end else begin
            collect_words(int'(a), b[0], 1'b0);
            expect_no_words(IDLE_CYCLES);
          end
        end
        "X": begin
          collect_words(int'(a), 1'b0, 1'b1);
          expect_no_words(IDLE_CYCLES);
        end
        "#", " ", 8'h0A, 8'h0D: begin
        end
        default: begin
          $display("ERROR: unknown command in input file: %s", line);
          abort_run();
        end
      endcase
    end
    $fclose(fd);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: bench/readout_tb_sva.sv
`timescale 1ns/10ps

module readout_tb_sva (
  input logic       clk156,
  input logic       rst_n_i,
  input logic       rbcp_act_i,
  input logic       rbcp_we_i,
  input logic       rbcp_re_i,
  input logic       rbcp_ack_o,
  input logic       tx_afull_i,
  input logic [3:0] tx_b_o,
  input logic       tim_1s_i,
  input logic       bled_o
);

  // every RBCP strobe gets its ack one cycle later
  a_ack_next: assert property (@(posedge clk156) disable iff (!rst_n_i)
    (rbcp_act_i && (rbcp_we_i || rbcp_re_i)) |=> rbcp_ack_o)
    else $error("RBCP strobe without ack in the next cycle");

  // at most one full word of bytes
  a_bytes_max: assert property (@(posedge clk156) disable iff (!rst_n_i)
    tx_b_o <= 4'd8)
    else $error("tx_b_o above 8");

  // almost full stalls the next cycle
  a_afull_stall: assert property (@(posedge clk156) disable iff (!rst_n_i)
    tx_afull_i |=> (tx_b_o == 4'd0))
    else $error("word sent right after almost full");

  // blue lamp moves only after a tick
  a_bled_tick: assert property (@(posedge clk156) disable iff (!rst_n_i)
    (bled_o != $past(bled_o)) |-> $past(tim_1s_i))
    else $error("bled_o changed without a tick");

endmodule

bind readout_top readout_tb_sva readout_tb_sva_inst (
  .clk156     (clk156),
  .rst_n_i    (rst_n_i),
  .rbcp_act_i (rbcp_act_i),
  .rbcp_we_i  (rbcp_we_i),
  .rbcp_re_i  (rbcp_re_i),
  .rbcp_ack_o (rbcp_ack_o),
  .tx_afull_i (tx_afull_i),
  .tx_b_o     (tx_b_o),
  .tim_1s_i   (tim_1s_i),
  .bled_o     (bled_o)
);

// File: bench/tb_input.txt
# cmd W addr data | R addr expected | S open | T tick | all values hex
# G words err (0 words: nothing may be sent) | X words, then the session closes
R 00000004 60
R 00000005 80
R 00000006 80
R 00000007 40
R 00000010 5C
R 00000014 1A
R 00000015 2B
R 00000016 3C
R 00000017 4D
R 00000000 00
R 00000002 00
W 00000003 FF
R 00000003 00
R 00000020 00
W 00000000 02
R 00000000 02
W 00000001 02
R 00000001 02
W 00000001 00
W 00000008 A7
R 00000008 A7
W 00000008 00
W 0000000F 3D
R 0000000F 3D
S 1
W 00000001 01
G 8 0
W 00000001 00
W 00000002 00
W 00000001 01
G 8 1
W 00000001 00
W 0000000F 18
W 00000001 03
G 3 0
W 00000001 02
W 00000004 DE
W 00000005 AD
W 00000006 BE
W 00000007 EF
R 00000007 EF
W 0000000F 10
W 00000001 03
G 2 0
W 00000001 00
W 00000000 00
W 00000001 01
G 0 0
W 00000001 00
W 00000000 02
S 0
W 00000001 01
G 0 0
W 00000001 00
S 1
W 0000000F 3D
W 00000001 01
X 3
S 1
G 0 0
W 00000001 00
W 00000001 01
G 8 0
W 00000001 00
T
T
T
S 0
S 1

// File: common/readout_pkg.sv
package readout_pkg;

  ////////////////////////////////////////////////////////////
  // transmit word geometry
  ////////////////////////////////////////////////////////////

  // bytes carried by one full TCP word
  localparam int BYTES_PER_WORD = 8;

  // single byte, as seen on RBCP and in the TX lanes
  typedef logic [7:0] byte_t;

  // one 64-bit TX word, two views of the same bits
  // index view used by the counter pattern
  // lane view used by error insertion, lane 7 goes out first
  typedef union packed {
    logic [63:0]      index;
    byte_t [7:0]      lane;
  } tx_word_u;

  ////////////////////////////////////////////////////////////
  // test settings
  ////////////////////////////////////////////////////////////

  // 2-bit mode register, only test mode runs the generator
  localparam logic [1:0] MODE_TEST = 2'd2;

  // sequence register after reset
  localparam logic [31:0] SEQ_PATTERN_DEFAULT = 32'h6080_8040;

  ////////////////////////////////////////////////////////////
  // RBCP register map, byte addresses
  ////////////////////////////////////////////////////////////

  // multi-byte fields are big endian
  // lowest address holds the most significant byte

  // mode, low 2 bits
  localparam logic [31:0] ADDR_MODE    = 32'h0000_0000;
  // bit 0 data_gen, bit 1 select_seq
  localparam logic [31:0] ADDR_CTRL    = 32'h0000_0001;
  // write only, any value fires one corrupted word
  localparam logic [31:0] ADDR_INS_ERR = 32'h0000_0002;
  // 0x04..0x07 sequence pattern
  localparam logic [31:0] ADDR_SEQ     = 32'h0000_0004;
  // 0x08..0x0f byte count to send
  localparam logic [31:0] ADDR_NUM     = 32'h0000_0008;
  // read only code version
  localparam logic [31:0] ADDR_VER     = 32'h0000_0010;
  // 0x14..0x17 read only build date
  localparam logic [31:0] ADDR_DATE    = 32'h0000_0014;

endpackage

// File: compile.f
common/readout_pkg.sv
design/rbcp_regs.sv
tcp_test/test_pattern.sv
tcp_test/tcp_test_gen.sv
design/readout_top.sv
bench/readout_tb_sva.sv
bench/readout_tb.sv

// File: design/rbcp_regs.sv
`timescale 1ns/10ps

module rbcp_regs #(
  parameter logic [31:0] SYN_DATE = 32'h0,
  parameter logic [7:0]  FPGA_VER = 8'h1
) (
  input  logic               clk156,
  input  logic               rst_n_i,
  // RBCP strobes
  input  logic               rbcp_act_i,
  input  logic [31:0]        rbcp_addr_i,
  input  logic               rbcp_we_i,
  input  readout_pkg::byte_t rbcp_wd_i,
  input  logic               rbcp_re_i,
  output readout_pkg::byte_t rbcp_rd_o,
  output logic               rbcp_ack_o,
  // test settings
  output logic [1:0]         mode_o,
  output logic               data_gen_o,
  output logic               select_seq_o,
  output logic [31:0]        seq_pattern_o,
  output logic [63:0]        num_of_data_o,
  output logic               ins_error_o
);

  // qualified strobes
  logic                      wr_en;
  logic                      rd_en;
  // address decode
  logic                      hit_mode;
  logic                      hit_ctrl;
  logic                      hit_ins;
  logic                      hit_seq;
  logic                      hit_num;
  logic                      hit_ver;
  logic                      hit_date;
  // byte lane inside a multi-byte field
  logic [1:0]                seq_lane;
  logic [2:0]                num_lane;
  logic [1:0]                date_lane;
  // read data before the ack register
  readout_pkg::byte_t        rd_byte;

  // setting registers
  logic [1:0]                mode_q;
  logic                      data_gen_q;
  logic                      select_seq_q;
  readout_pkg::byte_t [3:0]  seq_q;
  readout_pkg::byte_t [7:0]  num_q;
  logic                      ins_error_q;
  // response registers
  logic                      ack_q;
  readout_pkg::byte_t        rd_q;

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////

  // strobes only count inside an active transfer
  assign wr_en = rbcp_act_i & rbcp_we_i;
  assign rd_en = rbcp_act_i & rbcp_re_i;

  assign hit_mode = (rbcp_addr_i == readout_pkg::ADDR_MODE);
  assign hit_ctrl = (rbcp_addr_i == readout_pkg::ADDR_CTRL);
  assign hit_ins  = (rbcp_addr_i == readout_pkg::ADDR_INS_ERR);
  assign hit_ver  = (rbcp_addr_i == readout_pkg::ADDR_VER);
  // 4- and 8-byte fields, aligned blocks
  assign hit_seq  = ((rbcp_addr_i & ~32'h3) == readout_pkg::ADDR_SEQ);
  assign hit_num  = ((rbcp_addr_i & ~32'h7) == readout_pkg::ADDR_NUM);
  assign hit_date = ((rbcp_addr_i & ~32'h3) == readout_pkg::ADDR_DATE);

  // big endian, lowest address is the top lane
  assign seq_lane  = 2'd3 - rbcp_addr_i[1:0];
  assign num_lane  = 3'd7 - rbcp_addr_i[2:0];
  assign date_lane = 2'd3 - rbcp_addr_i[1:0];

  ////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk156 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mode_q       <= 2'd0;
      data_gen_q   <= 1'b0;
      select_seq_q <= 1'b0;
      seq_q        <= readout_pkg::SEQ_PATTERN_DEFAULT;
      num_q        <= '0;
      ins_error_q  <= 1'b0;
    end else begin
      // error request lasts one cycle, nothing stored
      ins_error_q <= wr_en & hit_ins;
      if (wr_en) begin
        if (hit_mode) begin
          mode_q <= rbcp_wd_i[1:0];
        end
        if (hit_ctrl) begin
          data_gen_q   <= rbcp_wd_i[0];
          select_seq_q <= rbcp_wd_i[1];
        end
        if (hit_seq) begin
          seq_q[seq_lane] <= rbcp_wd_i;
        end
        if (hit_num) begin
          num_q[num_lane] <= rbcp_wd_i;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////

  // unmapped and write-only addresses give 0
  always_comb begin
    rd_byte = 8'h00;
    if (hit_mode) begin
      rd_byte = {6'd0, mode_q};
    end else if (hit_ctrl) begin
      rd_byte = {6'd0, select_seq_q, data_gen_q};
    end else if (hit_seq) begin
      rd_byte = seq_q[seq_lane];
    end else if (hit_num) begin
      rd_byte = num_q[num_lane];
    end else if (hit_ver) begin
      rd_byte = FPGA_VER;
    end else if (hit_date) begin
      rd_byte = SYN_DATE[{date_lane, 3'b000} +: 8];
    end
  end

  // ack one cycle after either strobe
  // read byte only valid in that ack cycle
  always_ff @(posedge clk156 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
      rd_q  <= 8'h00;
    end else begin
      ack_q <= wr_en | rd_en;
      rd_q  <= rd_en ? rd_byte : 8'h00;
    end
  end

  assign rbcp_ack_o    = ack_q;
  assign rbcp_rd_o     = rd_q;
  assign mode_o        = mode_q;
  assign data_gen_o    = data_gen_q;
  assign select_seq_o  = select_seq_q;
  assign seq_pattern_o = seq_q;
  assign num_of_data_o = num_q;
  assign ins_error_o   = ins_error_q;

endmodule

// File: design/readout_top.sv
`timescale 1ns/10ps

module readout_top #(
  parameter logic [31:0] SYN_DATE = 32'h0,
  parameter logic [7:0]  FPGA_VER = 8'h1
) (
  input  logic               clk156,
  input  logic               rst_n_i,
  // RBCP slow control
  input  logic               rbcp_act_i,
  input  logic [31:0]        rbcp_addr_i,
  input  logic               rbcp_we_i,
  input  readout_pkg::byte_t rbcp_wd_i,
  input  logic               rbcp_re_i,
  output readout_pkg::byte_t rbcp_rd_o,
  output logic               rbcp_ack_o,
  // TCP session and TX side
  input  logic               tcp_open_i,
  input  logic               tx_afull_i,
  output logic [63:0]        tx_d_o,
  output logic [3:0]         tx_b_o,
  // timer and lamps
  input  logic               tim_1s_i,
  output logic               bled_o,
  output logic               gled_o
);

  // register bank to generator
  logic [1:0]  tcp_mode;
  logic        tcp_data_gen;
  logic        tcp_select_seq;
  logic [31:0] tcp_seq_pattern;
  logic [63:0] tcp_num_of_data;
  logic        tcp_ins_error;

  // blue lamp state
  logic        bled_q;

  ////////////////////////////////////////////////////////////
  // slow control registers
  ////////////////////////////////////////////////////////////

  rbcp_regs #(
    .SYN_DATE      (SYN_DATE),
    .FPGA_VER      (FPGA_VER)
  ) rbcp_regs_inst (
    .clk156        (clk156),
    .rst_n_i       (rst_n_i),
    .rbcp_act_i    (rbcp_act_i),
    .rbcp_addr_i   (rbcp_addr_i),
    .rbcp_we_i     (rbcp_we_i),
    .rbcp_wd_i     (rbcp_wd_i),
    .rbcp_re_i     (rbcp_re_i),
    .rbcp_rd_o     (rbcp_rd_o),
    .rbcp_ack_o    (rbcp_ack_o),
    .mode_o        (tcp_mode),
    .data_gen_o    (tcp_data_gen),
    .select_seq_o  (tcp_select_seq),
    .seq_pattern_o (tcp_seq_pattern),
    .num_of_data_o (tcp_num_of_data),
    .ins_error_o   (tcp_ins_error)
  );

  ////////////////////////////////////////////////////////////
  // TCP test data generator
  ////////////////////////////////////////////////////////////

  tcp_test_gen tcp_test_gen_inst (
    .clk156        (clk156),
    .rst_n_i       (rst_n_i),
    .mode_i        (tcp_mode),
    .data_gen_i    (tcp_data_gen),
    .select_seq_i  (tcp_select_seq),
    .seq_pattern_i (tcp_seq_pattern),
    .num_of_data_i (tcp_num_of_data),
    .ins_error_i   (tcp_ins_error),
    .tcp_open_i    (tcp_open_i),
    .tx_afull_i    (tx_afull_i),
    .tx_d_o        (tx_d_o),
    .tx_b_o        (tx_b_o)
  );

  ////////////////////////////////////////////////////////////
  // status lamps
  ////////////////////////////////////////////////////////////

  // blue lamp, flips on each one-second tick
  always_ff @(posedge clk156 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bled_q <= 1'b0;
    end else if (tim_1s_i) begin
      bled_q <= ~bled_q;
    end
  end

  assign bled_o = bled_q;
  // green lamp lit (low) while session is up
  assign gled_o = ~tcp_open_i;

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the readout testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module readout_tb \
  -f compile.f \
  -o readout_sim

./obj_dir/readout_sim

// File: tcp_test/tcp_test_gen.sv
`timescale 1ns/10ps

module tcp_test_gen (
  input  logic        clk156,
  input  logic        rst_n_i,
  // settings from the register bank
  input  logic [1:0]  mode_i,
  input  logic        data_gen_i,
  input  logic        select_seq_i,
  input  logic [31:0] seq_pattern_i,
  input  logic [63:0] num_of_data_i,
  input  logic        ins_error_i,
  // TCP session and TX FIFO
  input  logic        tcp_open_i,
  input  logic        tx_afull_i,
  output logic [63:0] tx_d_o,
  output logic [3:0]  tx_b_o
);

  // run control
  logic                  data_gen_q;
  logic                  enable;
  logic                  start;
  logic                  send;
  logic                  running_q;
  // byte budget
  logic [63:0]           remain_q;
  logic                  last_word;
  logic [3:0]            chunk;
  // current pattern word
  readout_pkg::tx_word_u word;
  // output registers
  logic [63:0]           tx_d_q;
  logic [3:0]            tx_b_q;

  ////////////////////////////////////////////////////////////
  // start and gating
  ////////////////////////////////////////////////////////////

  // all three must hold for the whole run
  assign enable = (mode_i == readout_pkg::MODE_TEST) & tcp_open_i & data_gen_i;
  // fresh rising edge of data_gen only
  assign start  = enable & ~data_gen_q;
  // FIFO not almost full, take a word this cycle
  assign send   = running_q & enable & ~tx_afull_i;

  // tail word carries whatever is left
  assign last_word = (remain_q <= 64'(readout_pkg::BYTES_PER_WORD));
  assign chunk     = last_word ? remain_q[3:0] : 4'(readout_pkg::BYTES_PER_WORD);

  always_ff @(posedge clk156 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      data_gen_q <= 1'b0;
    end else begin
      data_gen_q <= data_gen_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // run state and budget
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk156 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      running_q <= 1'b0;
      remain_q  <= '0;
    end else if (start) begin
      // zero byte count gives no run at all
      running_q <= (num_of_data_i != 64'd0);
      remain_q  <= num_of_data_i;
    end else if (!enable) begin
      // session closed or data_gen dropped, stop at once
      running_q <= 1'b0;
    end else if (send) begin
      remain_q <= remain_q - 64'(chunk);
      if (last_word) begin
        running_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // word source
  ////////////////////////////////////////////////////////////

  // restart on run start, step on every word taken
  test_pattern test_pattern_inst (
    .clk156        (clk156),
    .rst_n_i       (rst_n_i),
    .restart_i     (start),
    .advance_i     (send),
    .select_seq_i  (select_seq_i),
    .seq_pattern_i (seq_pattern_i),
    .ins_error_i   (ins_error_i),
    .word_o        (word)
  );

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  // byte count 0 marks an empty cycle
  always_ff @(posedge clk156 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_b_q <= 4'd0;
    end else begin
      tx_b_q <= send ? chunk : 4'd0;
    end
  end

  // data only meaningful with a nonzero count
  always_ff @(posedge clk156 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_d_q <= '0;
    end else if (send) begin
      tx_d_q <= word.index;
    end
  end

  assign tx_d_o = tx_d_q;
  assign tx_b_o = tx_b_q;

endmodule

// File: tcp_test/test_pattern.sv
`timescale 1ns/10ps

module test_pattern (
  input  logic                  clk156,
  input  logic                  rst_n_i,
  // stepping from the generator
  input  logic                  restart_i,
  input  logic                  advance_i,
  // pattern select
  input  logic                  select_seq_i,
  input  logic [31:0]           seq_pattern_i,
  input  logic                  ins_error_i,
  output readout_pkg::tx_word_u word_o
);

  // word index within the run
  logic [63:0]           index_q;
  // one corrupted word pending
  logic                  err_armed_q;
  readout_pkg::tx_word_u word;

  ////////////////////////////////////////////////////////////
  // index and error flag
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk156 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      index_q <= '0;
    end else if (restart_i) begin
      index_q <= '0;
    end else if (advance_i) begin
      index_q <= index_q + 64'd1;
    end
  end

  // armed flag survives restart, so a request made
  // before a run hits that run's first word
  always_ff @(posedge clk156 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_armed_q <= 1'b0;
    end else if (ins_error_i) begin
      err_armed_q <= 1'b1;
    end else if (advance_i) begin
      // corrupted word just went out
      err_armed_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // word build
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (select_seq_i) begin
      // same pattern in both halves
      word.index = {seq_pattern_i, seq_pattern_i};
    end else begin
      word.index = index_q;
    end
    // invert first byte on the wire
    if (err_armed_q) begin
      word.lane[7] = ~word.lane[7];
    end
  end

  assign word_o = word;

endmodule
